// File: source/cpu_regs_pkg.sv
// register-side definitions
// register select codes and bank aliases
// register file sizes and operand size enum
// sized register write and pointer step structs
// operand size helpers for step and masking
`default_nettype none

package cpu_regs_pkg;

    // upper nibble: bank, pointer file or alias; lower nibble: byte index
    typedef logic [7:0] reg_sel_t;

    // alias codes resolved against the bank pointer
    localparam logic [3:0] BANK_CUR  = 4'he;
    localparam logic [3:0] BANK_PREV = 4'hd;

    localparam int NUM_ACC_BYTES = 64;
    localparam int NUM_PTR_BYTES = 16;

    // reads as zero, never written
    localparam reg_sel_t SEL_NONE = 8'h40;

    typedef enum logic [1:0] {
        SZ_BYTE,
        SZ_WORD,
        SZ_LONG
    } op_size_e;

    typedef struct packed {
        logic        en;
        op_size_e    size;
        reg_sel_t    sel;
        logic [31:0] data;
    } reg_wr_t;

    // mode carries a ptr_mode_e code
    typedef struct packed {
        logic [1:0] mode;
        op_size_e   size;
        reg_sel_t   sel;
    } ptr_upd_t;

    // byte count, also the pointer step
    function automatic logic [31:0] size_bytes(op_size_e sz);
        case (sz)
            SZ_BYTE: return 32'd1;
            SZ_WORD: return 32'd2;
            default: return 32'd4;
        endcase
    endfunction

    function automatic logic [31:0] size_mask(op_size_e sz);
        case (sz)
            SZ_BYTE: return 32'h0000_00ff;
            SZ_WORD: return 32'h0000_ffff;
            default: return 32'hffff_ffff;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: source/cpu_ops_pkg.sv
// command-side definitions
// opcode and pointer mode enums
// command struct and RAM request struct
// RAM depth
`default_nettype none

package cpu_ops_pkg;

    import cpu_regs_pkg::*;

    localparam int RAM_DEPTH = 256;

    typedef enum logic [1:0] {
        OP_LDI,
        OP_MOV,
        OP_LD,
        OP_ST
    } opcode_e;

    typedef enum logic [1:0] {
        PM_PLAIN,
        PM_INC,
        PM_DEC
    } ptr_mode_e;

    // src is the pointer for OP_LD and OP_ST
    typedef struct packed {
        opcode_e     op;
        op_size_e    size;
        ptr_mode_e   mode;
        reg_sel_t    dst;
        reg_sel_t    src;
        logic [31:0] imm;
    } cmd_t;

    // addr is the word address, low byte of the pointer
    typedef struct packed {
        logic        we;
        logic [7:0]  addr;
        logic [31:0] wdata;
    } mem_req_t;

endpackage

`default_nettype wire

// File: source/reg_file.sv
// banked register file
// accumulator banks XWA..XHL and pointers XIX..XSP
// current/previous bank alias resolution
// sized writes, pointer post-increment and pre-decrement
// registered debug dump port
`timescale 1ns/1ps
`default_nettype none

module reg_file
    import cpu_regs_pkg::*, cpu_ops_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic [1:0]  rfp,
    input  wire reg_sel_t    rd_a_sel,
    input  wire reg_sel_t    rd_b_sel,
    output logic      [31:0] rd_a_data,
    output logic      [31:0] rd_b_data,
    input  wire reg_wr_t     wr,
    input  wire ptr_upd_t    ptr_upd,
    output logic      [31:0] ptr_addr,
    input  wire logic [7:0]  dmp_addr,
    output logic      [7:0]  dmp_data
);

    logic [7:0] accs [NUM_ACC_BYTES];
    logic [7:0] ptrs [NUM_PTR_BYTES];

    reg_sel_t    wr_sel;
    reg_sel_t    upd_sel;
    logic [31:0] step;
    logic [31:0] upd_next;

    // alias codes to an explicit bank
    function automatic reg_sel_t resolve(reg_sel_t rs);
        logic [3:0] bank;
        case (rs[7:4])
            BANK_CUR:  bank = {2'b00, rfp};
            BANK_PREV: bank = {2'b00, rfp - 2'd1};
            default:   bank = rs[7:4];
        endcase
        return {bank, rs[3:0]};
    endfunction

    // byte k of a value within its 16-byte group
    function automatic logic [3:0] byte_pos(logic [3:0] idx, logic [1:0] k);
        case (k)
            2'd0:    return idx;
            2'd1:    return {idx[3:1], 1'b1};
            2'd2:    return {idx[3:2], 2'b10};
            default: return {idx[3:2], 2'b11};
        endcase
    endfunction

    // little-endian assembly, nibble 4 reads as zero
    function automatic logic [31:0] read_reg(reg_sel_t rs);
        logic [31:0] val;
        val = '0;
        if (rs[7:4] != 4'h4) begin
            for (int k = 0; k < 4; k++) begin
                if (rs[7])
                    val[8*k +: 8] = ptrs[byte_pos(rs[3:0], 2'(k))];
                else
                    val[8*k +: 8] = accs[{rs[5:4], byte_pos(rs[3:0], 2'(k))}];
            end
        end
        return val;
    endfunction

    always_comb begin
        rd_a_data = read_reg(resolve(rd_a_sel));
        rd_b_data = read_reg(resolve(rd_b_sel));
        step      = size_bytes(ptr_upd.size);
        // pre-decrement addresses with the stepped value
        if (ptr_upd.mode == PM_DEC)
            ptr_addr = rd_a_data - step;
        else
            ptr_addr = rd_a_data;
        wr_sel  = resolve(wr.sel);
        upd_sel = resolve(ptr_upd.sel);
        if (ptr_upd.mode == PM_DEC)
            upd_next = read_reg(upd_sel) - step;
        else
            upd_next = read_reg(upd_sel) + step;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_ACC_BYTES; i++)
                accs[i] <= '0;
            for (int i = 0; i < NUM_PTR_BYTES; i++)
                ptrs[i] <= '0;
        end else begin
            // sized write, low bytes only
            if (wr.en && wr_sel[7:4] != 4'h4) begin
                for (int k = 0; k < 4; k++) begin
                    if (k < size_bytes(wr.size)) begin
                        if (wr_sel[7])
                            ptrs[byte_pos(wr_sel[3:0], 2'(k))] <= wr.data[8*k +: 8];
                        else
                            accs[{wr_sel[5:4], byte_pos(wr_sel[3:0], 2'(k))}]
                                <= wr.data[8*k +: 8];
                    end
                end
            end
            // pointer step, pointer file only
            if (upd_sel[7] && (ptr_upd.mode == PM_INC || ptr_upd.mode == PM_DEC)) begin
                for (int k = 0; k < 4; k++)
                    ptrs[byte_pos(upd_sel[3:0], 2'(k))] <= upd_next[8*k +: 8];
            end
        end
    end

    // debug dump, accumulators then pointers
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            dmp_data <= '0;
        else if (dmp_addr < 8'h40)
            dmp_data <= accs[dmp_addr[5:0]];
        else if (dmp_addr < 8'h50)
            dmp_data <= ptrs[dmp_addr[3:0]];
        else
            dmp_data <= '0;
    end

endmodule

`default_nettype wire

// File: source/op_sequencer.sv
// command sequencer
// FSM for immediate, move, load and store commands
// builds RAM requests from the effective pointer
// drives register reads, writes and pointer steps
`timescale 1ns/1ps
`default_nettype none

module op_sequencer
    import cpu_regs_pkg::*, cpu_ops_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire cmd_t        cmd,
    input  wire logic        cmd_valid,
    output logic             busy,
    output logic             done,
    output reg_sel_t         rd_a_sel,
    output reg_sel_t         rd_b_sel,
    input  wire logic [31:0] rd_a_data,
    input  wire logic [31:0] rd_b_data,
    input  wire logic [31:0] ptr_addr,
    output reg_wr_t          wr,
    output ptr_upd_t         ptr_upd,
    output logic             seq_req,
    output mem_req_t         seq_mreq,
    input  wire logic        seq_gnt,
    input  wire logic        seq_rvalid,
    input  wire logic [31:0] seq_rdata
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_MEM,
        ST_LOAD_WAIT,
        ST_DONE
    } state_e;

    state_e      state;
    cmd_t        cur;
    logic [31:0] mask;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (cmd_valid)
                        state <= (cmd.op == OP_LD || cmd.op == OP_ST) ? ST_MEM : ST_DONE;
                end
                ST_MEM: begin
                    if (seq_gnt)
                        state <= (cur.op == OP_LD) ? ST_LOAD_WAIT : ST_DONE;
                end
                ST_LOAD_WAIT: begin
                    if (seq_rvalid)
                        state <= ST_DONE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // latched command
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && cmd_valid)
            cur <= cmd;
    end

    always_comb begin
        busy    = (state != ST_IDLE);
        done    = (state == ST_DONE);
        seq_req = (state == ST_MEM);
        mask    = size_mask(cur.size);

        // pointer on port a, data source on port b
        rd_a_sel = cur.src;
        rd_b_sel = (cur.op == OP_ST) ? cur.dst : cur.src;

        seq_mreq.we    = (cur.op == OP_ST);
        seq_mreq.addr  = ptr_addr[7:0];
        seq_mreq.wdata = rd_b_data & mask;

        // mode held for the address, step only at the grant edge
        ptr_upd.mode = cur.mode;
        ptr_upd.size = cur.size;
        ptr_upd.sel  = (seq_req && seq_gnt) ? cur.src : SEL_NONE;

        wr.en   = (done && (cur.op == OP_LDI || cur.op == OP_MOV))
               || (state == ST_LOAD_WAIT && seq_rvalid);
        wr.size = cur.size;
        wr.sel  = cur.dst;
        case (cur.op)
            OP_LDI:  wr.data = cur.imm & mask;
            OP_MOV:  wr.data = rd_b_data & mask;
            default: wr.data = seq_rdata & mask;
        endcase
    end

endmodule

`default_nettype wire

// File: source/mem_arbiter.sv
// RAM port arbiter
// fixed priority, sequencer over host
// read-valid steering to the owner of the pending read
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter
    import cpu_ops_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     seq_req,
    input  wire mem_req_t seq_mreq,
    output logic          seq_gnt,
    output logic          seq_rvalid,
    input  wire logic     host_req,
    input  wire mem_req_t host_mreq,
    output logic          host_gnt,
    output logic          host_rvalid,
    output logic          ram_en,
    output mem_req_t      ram_req
);

    // grant in the same cycle the RAM is enabled
    always_comb begin
        seq_gnt  = seq_req;
        host_gnt = host_req && !seq_req;
        ram_en   = seq_req || host_req;
        ram_req  = seq_req ? seq_mreq : host_mreq;
    end

    // read data shows up one cycle later on the shared bus
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            seq_rvalid  <= 1'b0;
            host_rvalid <= 1'b0;
        end else begin
            seq_rvalid  <= seq_gnt && !seq_mreq.we;
            host_rvalid <= host_gnt && !host_mreq.we;
        end
    end

endmodule

`default_nettype wire

// File: source/data_ram.sv
// data memory
// 256 x 32 single port, registered read data
`timescale 1ns/1ps
`default_nettype none

module data_ram
    import cpu_ops_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        ram_en,
    input  wire mem_req_t    ram_req,
    output logic      [31:0] ram_rdata
);

    logic [31:0] mem [RAM_DEPTH];

    always_ff @(posedge clk) begin
        if (ram_en) begin
            if (ram_req.we)
                mem[ram_req.addr] <= ram_req.wdata;
            else
                ram_rdata <= mem[ram_req.addr];
        end
    end

endmodule

`default_nettype wire

// File: source/cpu_core_top.sv
// CPU register and operand-memory slice
// register file, command sequencer, RAM arbiter and data RAM
`timescale 1ns/1ps
`default_nettype none

module cpu_core_top
    import cpu_regs_pkg::*, cpu_ops_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic [1:0]  rfp,
    input  wire cmd_t        cmd,
    input  wire logic        cmd_valid,
    output logic             busy,
    output logic             done,
    input  wire logic        host_req,
    input  wire mem_req_t    host_mreq,
    output logic             host_gnt,
    output logic      [31:0] host_rdata,
    output logic             host_rvalid,
    input  wire logic [7:0]  dmp_addr,
    output logic      [7:0]  dmp_data
);

    reg_sel_t    rd_a_sel;
    reg_sel_t    rd_b_sel;
    logic [31:0] rd_a_data;
    logic [31:0] rd_b_data;
    logic [31:0] ptr_addr;
    reg_wr_t     wr;
    ptr_upd_t    ptr_upd;

    logic        seq_req;
    mem_req_t    seq_mreq;
    logic        seq_gnt;
    logic        seq_rvalid;
    logic        ram_en;
    mem_req_t    ram_req;
    logic [31:0] ram_rdata;

    // shared read bus
    assign host_rdata = ram_rdata;

    reg_file i_reg_file (
        .clk       (clk),
        .rst       (rst),
        .rfp       (rfp),
        .rd_a_sel  (rd_a_sel),
        .rd_b_sel  (rd_b_sel),
        .rd_a_data (rd_a_data),
        .rd_b_data (rd_b_data),
        .wr        (wr),
        .ptr_upd   (ptr_upd),
        .ptr_addr  (ptr_addr),
        .dmp_addr  (dmp_addr),
        .dmp_data  (dmp_data)
    );

    op_sequencer i_op_sequencer (
        .clk        (clk),
        .rst        (rst),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .busy       (busy),
        .done       (done),
        .rd_a_sel   (rd_a_sel),
        .rd_b_sel   (rd_b_sel),
        .rd_a_data  (rd_a_data),
        .rd_b_data  (rd_b_data),
        .ptr_addr   (ptr_addr),
        .wr         (wr),
        .ptr_upd    (ptr_upd),
        .seq_req    (seq_req),
        .seq_mreq   (seq_mreq),
        .seq_gnt    (seq_gnt),
        .seq_rvalid (seq_rvalid),
        .seq_rdata  (ram_rdata)
    );

    mem_arbiter i_mem_arbiter (
        .clk         (clk),
        .rst         (rst),
        .seq_req     (seq_req),
        .seq_mreq    (seq_mreq),
        .seq_gnt     (seq_gnt),
        .seq_rvalid  (seq_rvalid),
        .host_req    (host_req),
        .host_mreq   (host_mreq),
        .host_gnt    (host_gnt),
        .host_rvalid (host_rvalid),
        .ram_en      (ram_en),
        .ram_req     (ram_req)
    );

    data_ram i_data_ram (
        .clk       (clk),
        .ram_en    (ram_en),
        .ram_req   (ram_req),
        .ram_rdata (ram_rdata)
    );

endmodule

`default_nettype wire

// File: dv/clk_gen.sv
// testbench clock and reset
// 40 ns clock period, reset held for 5 cycles
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // released on a falling edge like every other input
    initial begin
        rst = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// File: dv/tb_top.sv
// testbench top
// random commands and host traffic from an LCG
// reference model of register bytes and RAM words
// dump sweeps and host read-back checks
`timescale 1ns/1ps
`default_nettype none

module tb_top
    import cpu_regs_pkg::*, cpu_ops_pkg::*;
();

    localparam int TIMEOUT = 100;

    logic        clk;
    logic        rst;
    logic [1:0]  rfp;
    cmd_t        cmd;
    logic        cmd_valid;
    logic        busy;
    logic        done;
    logic        host_req;
    mem_req_t    host_mreq;
    logic        host_gnt;
    logic [31:0] host_rdata;
    logic        host_rvalid;
    logic [7:0]  dmp_addr;
    logic [7:0]  dmp_data;

    // dump layout, accumulators 0..63 then pointers 64..79
    logic [7:0]  model_regs [80];
    logic [31:0] model_ram [RAM_DEPTH];

    logic [31:0] lcg_state;
    int          errors;
    int          checks;
    int          failed_tests;
    int          test_start;
    int          host_issued;
    bit          seq_running;

    clk_gen i_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    cpu_core_top i_dut (
        .clk         (clk),
        .rst         (rst),
        .rfp         (rfp),
        .cmd         (cmd),
        .cmd_valid   (cmd_valid),
        .busy        (busy),
        .done        (done),
        .host_req    (host_req),
        .host_mreq   (host_mreq),
        .host_gnt    (host_gnt),
        .host_rdata  (host_rdata),
        .host_rvalid (host_rvalid),
        .dmp_addr    (dmp_addr),
        .dmp_data    (dmp_data)
    );

    function automatic logic [15:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:16];
    endfunction

    // operand size in bytes, also the pointer step
    function automatic int byte_count(op_size_e sz);
        case (sz)
            SZ_BYTE: return 1;
            SZ_WORD: return 2;
            default: return 4;
        endcase
    endfunction

    // flat model index of byte k, aligned indices only
    function automatic int model_index(reg_sel_t sel, int k);
        int bank;
        if (sel[7:4] == 4'h8)
            return 64 + int'(sel[3:0]) + k;
        if (sel[7:4] == BANK_CUR)
            bank = int'(rfp);
        else if (sel[7:4] == BANK_PREV)
            bank = (int'(rfp) + 3) % 4;
        else
            bank = int'(sel[7:4]);
        return bank * 16 + int'(sel[3:0]) + k;
    endfunction

    function automatic logic [31:0] model_read(reg_sel_t sel, int n);
        logic [31:0] val;
        val = '0;
        if (sel[7:4] != 4'h4) begin
            for (int k = 0; k < n; k++)
                val[8*k +: 8] = model_regs[model_index(sel, k)];
        end
        return val;
    endfunction

    function automatic void model_write(reg_sel_t sel, int n, logic [31:0] data);
        if (sel[7:4] != 4'h4) begin
            for (int k = 0; k < n; k++)
                model_regs[model_index(sel, k)] = data[8*k +: 8];
        end
    endfunction

    // pointer step lands before the load data
    function automatic void apply_cmd(cmd_t c);
        int          n;
        logic [31:0] ptr;
        logic [31:0] data;
        logic [7:0]  addr;
        n = byte_count(c.size);
        case (c.op)
            OP_LDI: model_write(c.dst, n, c.imm);
            OP_MOV: model_write(c.dst, n, model_read(c.src, n));
            default: begin
                ptr  = model_read(c.src, 4);
                data = model_read(c.dst, n);
                if (c.mode == PM_DEC)
                    ptr = ptr - 32'(n);
                addr = ptr[7:0];
                if (c.mode == PM_INC)
                    ptr = ptr + 32'(n);
                if (c.mode != PM_PLAIN)
                    model_write(c.src, 4, ptr);
                if (c.op == OP_ST)
                    model_ram[addr] = data;
                else
                    model_write(c.dst, n, model_ram[addr]);
            end
        endcase
    endfunction

    // banks 0..3, current, previous, pointer file, zero
    function automatic reg_sel_t pick_sel(op_size_e sz, int choices);
        logic [15:0] r;
        logic [3:0]  nib;
        logic [3:0]  idx;
        int          code;
        r    = next_rand();
        code = int'(r[15:8]) % choices;
        case (code)
            4:       nib = BANK_CUR;
            5:       nib = BANK_PREV;
            6:       nib = 4'h8;
            7:       nib = 4'h4;
            default: nib = 4'(code);
        endcase
        case (sz)
            SZ_BYTE: idx = r[3:0];
            SZ_WORD: idx = {r[3:1], 1'b0};
            default: idx = {r[3:2], 2'b00};
        endcase
        return {nib, idx};
    endfunction

    function automatic op_size_e pick_size();
        logic [15:0] r;
        r = next_rand();
        case (int'(r[15:8]) % 3)
            0:       return SZ_BYTE;
            1:       return SZ_WORD;
            default: return SZ_LONG;
        endcase
    endfunction

    function automatic ptr_mode_e pick_mode();
        logic [15:0] r;
        r = next_rand();
        case (int'(r[15:8]) % 3)
            0:       return PM_PLAIN;
            1:       return PM_INC;
            default: return PM_DEC;
        endcase
    endfunction

    // memory commands point through XIX..XSP
    function automatic cmd_t random_cmd(opcode_e op, bit acc_dst);
        cmd_t        c;
        logic [15:0] r;
        c.op   = op;
        c.size = pick_size();
        c.mode = pick_mode();
        c.imm  = {next_rand(), next_rand()};
        if (op == OP_LDI || op == OP_MOV) begin
            c.dst = pick_sel(c.size, 8);
            c.src = pick_sel(c.size, 8);
        end else begin
            r     = next_rand();
            c.src = {4'h8, r[9:8], 2'b00};
            c.dst = pick_sel(c.size, acc_dst ? 6 : 8);
        end
        return c;
    endfunction

    task automatic timeout_fail(input string what);
        $display("timeout while waiting for %s at %0t", what, $time);
        $display("RESULT: FAIL");
        $finish;
    endtask

    task automatic finish_test(input int num, input string name);
        if (errors == test_start) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, errors - test_start);
            failed_tests++;
        end
        test_start = errors;
    endtask

    // dump is registered, so data trails the address by one cycle
    task automatic dump_check(input string what);
        for (int a = 0; a <= 80; a++) begin
            @(negedge clk);
            if (a < 80)
                dmp_addr = 8'(a);
            if (a > 0) begin
                checks++;
                if (dmp_data !== model_regs[a-1]) begin
                    $display("MISMATCH at %0t: %s dump[%02h] got %02h expected %02h",
                             $time, what, a - 1, dmp_data, model_regs[a-1]);
                    errors++;
                end
            end
        end
    endtask

    task automatic run_cmd(input cmd_t c, input logic [1:0] bank, input bit junk);
        int cnt;
        @(negedge clk);
        rfp       = bank;
        cmd       = c;
        cmd_valid = 1'b1;
        apply_cmd(c);
        @(negedge clk);
        cmd_valid = 1'b0;
        // a strobe while busy has to be dropped
        if (junk) begin
            checks++;
            if (!busy) begin
                $display("busy was low in the cycle after a command was accepted");
                errors++;
            end else begin
                cmd       = random_cmd(OP_LDI, 1'b0);
                cmd_valid = 1'b1;
            end
        end
        cnt = 0;
        while (!done) begin
            @(negedge clk);
            cmd_valid = 1'b0;
            cnt++;
            if (cnt > TIMEOUT)
                timeout_fail("done after a command");
        end
        @(negedge clk);
        cmd_valid = 1'b0;
    endtask

    task automatic host_access(input logic we, input logic [7:0] addr,
                               input logic [31:0] data);
        int cnt;
        @(negedge clk);
        host_req        = 1'b1;
        host_mreq.we    = we;
        host_mreq.addr  = addr;
        host_mreq.wdata = data;
        host_issued++;
        #1;
        cnt = 0;
        while (!host_gnt) begin
            @(negedge clk);
            #1;
            cnt++;
            if (cnt > TIMEOUT)
                timeout_fail("host_gnt");
        end
        if (we)
            model_ram[addr] = data;
        @(negedge clk);
        host_req = 1'b0;
        if (!we) begin
            cnt = 0;
            while (!host_rvalid) begin
                @(negedge clk);
                cnt++;
                if (cnt > TIMEOUT)
                    timeout_fail("host_rvalid");
            end
            checks++;
            if (host_rdata !== model_ram[addr]) begin
                $display("MISMATCH at %0t: host read [%02h] got %08h expected %08h",
                         $time, addr, host_rdata, model_ram[addr]);
                errors++;
            end
        end
    endtask

    initial begin
        cmd_t        c;
        cmd_t        mc;
        logic [15:0] r;
        logic [15:0] hr;
        int          cnt;
        rfp          = 2'd0;
        cmd          = '0;
        cmd_valid    = 1'b0;
        host_req     = 1'b0;
        host_mreq    = '0;
        dmp_addr     = 8'h00;
        lcg_state    = 32'd88;
        errors       = 0;
        checks       = 0;
        failed_tests = 0;
        test_start   = 0;
        host_issued  = 0;
        for (int i = 0; i < 80; i++)
            model_regs[i] = '0;
        for (int i = 0; i < RAM_DEPTH; i++)
            model_ram[i] = '0;

        cnt = 0;
        while (rst !== 1'b0) begin
            @(negedge clk);
            cnt++;
            if (cnt > TIMEOUT)
                timeout_fail("reset release");
        end

        dump_check("reset");
        finish_test(1, "reset dump");

        // immediates and moves under a changing bank pointer
        for (int i = 0; i < 40; i++) begin
            r = next_rand();
            if (r[0])
                c = random_cmd(OP_MOV, 1'b0);
            else
                c = random_cmd(OP_LDI, 1'b0);
            run_cmd(c, r[5:4], 1'b0);
        end
        dump_check("ldi/mov");
        finish_test(2, "ldi/mov");

        for (int a = 0; a < RAM_DEPTH; a++)
            host_access(1'b1, 8'(a), {8'(a), 8'h5a, next_rand()});
        for (int i = 0; i < 24; i++) begin
            r = next_rand();
            run_cmd(random_cmd(OP_LD, 1'b0), r[5:4], 1'b0);
        end
        dump_check("load");
        finish_test(3, "pointer loads");

        for (int i = 0; i < 24; i++) begin
            r = next_rand();
            run_cmd(random_cmd(OP_ST, 1'b0), r[5:4], 1'b0);
        end
        for (int a = 0; a < RAM_DEPTH; a++)
            host_access(1'b0, 8'(a), 32'h0);
        finish_test(4, "pointer stores");

        // pointers start low so sequencer traffic stays below 0x80
        for (int p = 0; p < 4; p++) begin
            c      = random_cmd(OP_LDI, 1'b0);
            c.size = SZ_LONG;
            c.dst  = {4'h8, 2'(p), 2'b00};
            c.imm  = 32'h38 + 32'(8 * (p % 2));
            run_cmd(c, rfp, 1'b0);
        end
        host_issued = 0;
        seq_running = 1'b1;
        fork
            begin
                for (int i = 0; i < 12; i++) begin
                    r = next_rand();
                    if (r[0])
                        mc = random_cmd(OP_ST, 1'b1);
                    else
                        mc = random_cmd(OP_LD, 1'b1);
                    run_cmd(mc, r[5:4], 1'b1);
                end
                seq_running = 1'b0;
            end
            begin
                while (seq_running && host_issued < 400) begin
                    hr = next_rand();
                    host_access(hr[0], {1'b1, hr[7:1]}, {next_rand(), next_rand()});
                end
            end
        join
        dump_check("contention");
        finish_test(5, "contention");

        $display("summary: 5 tests, %0d failed, %0d checks, %0d errors",
                 failed_tests, checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
source/cpu_regs_pkg.sv
source/cpu_ops_pkg.sv
source/reg_file.sv
source/op_sequencer.sv
source/mem_arbiter.sv
source/data_ram.sv
source/cpu_core_top.sv
dv/clk_gen.sv
dv/tb_top.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/1ps \
    -f filelist.f \
    --top-module tb_top \
    -o tb_sim

./obj_dir/tb_sim | tee sim.log

# the log decides pass or fail
grep -q "RESULT: PASS" sim.log
